// ==== design/hostCorePkg.sv ====
package hostCorePkg;

	// --------------------------------------------------
	// host pipe and link widths
	// --------------------------------------------------

	typedef logic [31:0] hostWord_t; // one pipe-in / pipe-out word
	typedef logic [10:0] flit_t;     // one board link flit

	// register file addressing
	typedef logic [4:0]  regId_t;    // 32 registers
	typedef logic [15:0] regData_t;  // 16 bit payload per register

	// serializer FSM, one state per flit plus idle
	typedef enum logic [1:0] {
		IDLE,
		FLIT0,  // bits 31:21 on the link
		FLIT1,  // bits 20:10
		FLIT2   // bits 9:0, msb of flit forced low
	} serState_t;

	localparam int FLITS_PER_WORD = 3; // three flits carry one host word

	// control register
	localparam regId_t REG_CTRL      = 5'd0;
	localparam int     TX_ENABLE_BIT = 0;  // gates the outbound link

	// --------------------------------------------------
	// pipe-in word classes
	// --------------------------------------------------

	// register write: 10 in bits 31:30, 0 in bit 29
	localparam logic [1:0] REG_WRITE_TAG = 2'b10;

	// nop: 10000 in bits 31:27 with an all-zero tail
	// the same prefix with a nonzero tail is a write to regs 0..7
	localparam logic [4:0] NOP_TAG = 5'b10000;

endpackage

// ==== design/hostWordDecoder.sv ====
`timescale 1ns/1ps

module hostWordDecoder (
	input  logic                   top_in_clk,
	input  logic                   arstN,
	input  logic                   pipeInWrite,  // one-cycle strobe per word
	input  hostCorePkg::hostWord_t pipeInData,
	input  hostCorePkg::regId_t    regReadAddr,  // host readback address
	output hostCorePkg::regData_t  regReadData,
	output logic                   txEnable,     // ctrl reg bit, gates the link
	output logic                   packetPush,   // toward the outbound fifo
	output hostCorePkg::hostWord_t packetData
);
	import hostCorePkg::*;

	localparam int NUM_REGS = 1 << $bits(regId_t); // full 5 bit address space

	regData_t regFile [NUM_REGS]; // host visible register file

	logic   isNop;      // word carries nothing
	logic   isRegWrite; // word targets the register file
	logic   isPacket;   // everything else goes to the link
	regId_t writeId;

	// --------------------------------------------------
	// word classification
	// --------------------------------------------------

	// nop wins over the overlapping register write pattern
	assign isNop = (pipeInData[31:27] == NOP_TAG) && (pipeInData[26:0] == '0);

	assign isRegWrite = (pipeInData[31:30] == REG_WRITE_TAG)
		&& !pipeInData[29]
		&& !isNop;

	assign isPacket = !isRegWrite && !isNop;

	assign writeId = pipeInData[28:24]; // register index field

	// --------------------------------------------------
	// register file
	// --------------------------------------------------

	// all registers clear on reset, so the link starts disabled
	always_ff @(posedge top_in_clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regFile[i] <= '0;
			end
		end else if (pipeInWrite && isRegWrite) begin
			regFile[writeId] <= pipeInData[15:0]; // low half is the data
		end
	end

	assign regReadData = regFile[regReadAddr]; // combinational readback

	assign txEnable = regFile[REG_CTRL][TX_ENABLE_BIT];

	// --------------------------------------------------
	// packet path
	// --------------------------------------------------

	// one-cycle push pulse for every packet word
	always_ff @(posedge top_in_clk or negedge arstN) begin
		if (!arstN) begin
			packetPush <= 1'b0;
		end else begin
			packetPush <= pipeInWrite && isPacket;
		end
	end

	// payload follows the strobe
	always_ff @(posedge top_in_clk) begin
		if (pipeInWrite && isPacket) begin
			packetData <= pipeInData;
		end
	end

endmodule

// ==== design/wordFifo.sv ====
`timescale 1ns/1ps

module wordFifo #(
	parameter int FIFO_DEPTH_LOG2 = 3  // depth is a power of two
) (
	input  logic                   top_in_clk,
	input  logic                   arstN,
	input  logic                   push,
	input  hostCorePkg::hostWord_t pushData,
	input  logic                   pop,
	output hostCorePkg::hostWord_t headData, // always the oldest word
	output logic                   empty,
	output logic                   full
);
	import hostCorePkg::*;

	// count is one bit wider than the pointers so full is reachable
	localparam logic [FIFO_DEPTH_LOG2:0] DEPTH = {1'b1, {FIFO_DEPTH_LOG2{1'b0}}};

	hostWord_t mem [1 << FIFO_DEPTH_LOG2]; // storage, no reset

	logic [FIFO_DEPTH_LOG2-1:0] rdPtr; // wraps on its own
	logic [FIFO_DEPTH_LOG2-1:0] wrPtr;
	logic [FIFO_DEPTH_LOG2:0]   count; // occupancy

	logic doPush; // qualified push
	logic doPop;  // qualified pop

	assign empty = (count == '0);
	assign full  = (count == DEPTH);

	assign doPush = push && !full;  // push into a full fifo is dropped
	assign doPop  = pop && !empty;  // pop of an empty fifo does nothing

	assign headData = mem[rdPtr];

	// --------------------------------------------------
	// pointers and occupancy
	// --------------------------------------------------

	always_ff @(posedge top_in_clk or negedge arstN) begin
		if (!arstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// data array
	always_ff @(posedge top_in_clk) begin
		if (doPush) begin
			mem[wrPtr] <= pushData;
		end
	end

endmodule

// ==== design/linkSerializer.sv ====
`timescale 1ns/1ps

module linkSerializer (
	input  logic                   top_in_clk,
	input  logic                   arstN,
	input  logic                   wordValid,   // outbound fifo not empty
	input  hostCorePkg::hostWord_t wordData,    // fifo head
	input  logic                   txEnable,
	input  logic                   topReadyIn,  // far board can take a flit
	output logic                   wordPop,     // fifo pop at the last flit
	output hostCorePkg::flit_t     topOut,
	output logic                   topValidOut
);
	import hostCorePkg::*;

	serState_t state;
	serState_t nextState;
	hostWord_t wordReg;   // word being sent, frees the fifo head
	logic      flitTaken; // handshake this cycle
	logic      startWord;

	assign startWord = (state == IDLE) && wordValid && txEnable;

	assign topValidOut = (state != IDLE);       // valid straight from state
	assign flitTaken   = topValidOut && topReadyIn;
	assign wordPop     = flitTaken && (state == FLIT2);

	// --------------------------------------------------
	// FSM
	// --------------------------------------------------

	always_comb begin
		nextState = state;
		case (state)
			IDLE:    if (startWord) nextState = FLIT0; // txEnable only gates the start
			FLIT0:   if (flitTaken) nextState = FLIT1;
			FLIT1:   if (flitTaken) nextState = FLIT2;
			FLIT2:   if (flitTaken) nextState = IDLE;  // head is popped here
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge top_in_clk or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	// capture the head when leaving idle
	always_ff @(posedge top_in_clk) begin
		if (startWord) begin
			wordReg <= wordData;
		end
	end

	// --------------------------------------------------
	// flit select
	// --------------------------------------------------

	// held word and state are both registers, so topOut is stable under stall
	always_comb begin
		case (state)
			FLIT0:   topOut = wordReg[31:21];
			FLIT1:   topOut = wordReg[20:10];
			FLIT2:   topOut = {1'b0, wordReg[9:0]}; // short last flit
			default: topOut = '0;                   // idle, not valid
		endcase
	end

endmodule

// ==== design/linkDeserializer.sv ====
`timescale 1ns/1ps

module linkDeserializer (
	input  logic                   top_in_clk,
	input  logic                   arstN,
	input  hostCorePkg::flit_t     topIn,
	input  logic                   topValidIn,
	input  logic                   fifoFull,    // inbound fifo has no room
	output logic                   topReadyOut,
	output logic                   wordPush,    // one cycle after the third flit
	output hostCorePkg::hostWord_t wordData
);
	import hostCorePkg::*;

	// index of the short flit that completes a word
	localparam logic [1:0] LAST_FLIT = 2'(FLITS_PER_WORD - 1);

	logic [1:0]  flitCnt;   // flits of the current word taken so far
	logic [21:0] shiftReg;  // first two flits, oldest in the upper half
	logic        flitTaken; // inbound handshake
	logic        lastFlit;  // next flit closes the word

	assign lastFlit = (flitCnt == LAST_FLIT);

	// --------------------------------------------------
	// back-pressure
	// --------------------------------------------------

	// only the closing flit needs room, earlier flits just shift in
	// a pushed word reaches the fifo before the next third flit can arrive
	assign topReadyOut = !(fifoFull && lastFlit);

	assign flitTaken = topValidIn && topReadyOut;

	// --------------------------------------------------
	// flit counter and push strobe
	// --------------------------------------------------

	always_ff @(posedge top_in_clk or negedge arstN) begin
		if (!arstN) begin
			flitCnt  <= '0;
			wordPush <= 1'b0;
		end else begin
			wordPush <= flitTaken && lastFlit; // registered push
			if (flitTaken) begin
				if (lastFlit) begin
					flitCnt <= '0;              // word done, restart
				end else begin
					flitCnt <= flitCnt + 1'b1;
				end
			end
		end
	end

	// --------------------------------------------------
	// word assembly
	// --------------------------------------------------

	always_ff @(posedge top_in_clk) begin
		if (flitTaken) begin
			if (lastFlit) begin
				wordData <= {shiftReg, topIn[9:0]}; // bit 10 of the last flit dropped
			end else begin
				shiftReg <= {shiftReg[10:0], topIn}; // 31:21 then 20:10
			end
		end
	end

endmodule

// ==== design/hostCore.sv ====
`timescale 1ns/1ps

module hostCore #(
	parameter int FIFO_DEPTH_LOG2 = 3  // both word fifos
) (
	input  logic                   top_in_clk,
	input  logic                   arstN,

	// host pipes
	input  logic                   pipeInWrite,
	input  hostCorePkg::hostWord_t pipeInData,
	input  logic                   pipeOutRead,
	input  hostCorePkg::regId_t    regReadAddr,
	output logic                   pipeInFull,   // outbound fifo full
	output hostCorePkg::hostWord_t pipeOutData,  // inbound fifo head
	output logic                   pipeOutEmpty,
	output hostCorePkg::regData_t  regReadData,

	// inbound link
	input  hostCorePkg::flit_t     topIn,
	input  logic                   topValidIn,
	output logic                   topReadyOut,

	// outbound link
	output hostCorePkg::flit_t     topOut,
	output logic                   topValidOut,
	input  logic                   topReadyIn
);
	import hostCorePkg::*;

	logic      txEnable;   // ctrl register bit
	logic      packetPush; // decoder to tx fifo
	hostWord_t packetData;
	hostWord_t txHead;     // tx fifo to serializer
	logic      txEmpty;
	logic      txPop;
	logic      rxPush;     // deserializer to rx fifo
	hostWord_t rxData;
	logic      rxFull;

	// --------------------------------------------------
	// input side, host words and register file
	// --------------------------------------------------

	hostWordDecoder decoder0 (
		.top_in_clk  (top_in_clk),
		.arstN       (arstN),
		.pipeInWrite (pipeInWrite),
		.pipeInData  (pipeInData),
		.regReadAddr (regReadAddr),
		.regReadData (regReadData),
		.txEnable    (txEnable),
		.packetPush  (packetPush),
		.packetData  (packetData)
	);

	// outbound queue, host to link
	wordFifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) txFifo0 (
		.top_in_clk (top_in_clk),
		.arstN      (arstN),
		.push       (packetPush),
		.pushData   (packetData),
		.pop        (txPop),
		.headData   (txHead),
		.empty      (txEmpty),
		.full       (pipeInFull)  // host watches this before writing
	);

	// --------------------------------------------------
	// output side, link flits
	// --------------------------------------------------

	linkSerializer ser0 (
		.top_in_clk  (top_in_clk),
		.arstN       (arstN),
		.wordValid   (!txEmpty),
		.wordData    (txHead),
		.txEnable    (txEnable),
		.topReadyIn  (topReadyIn),
		.wordPop     (txPop),
		.topOut      (topOut),
		.topValidOut (topValidOut)
	);

	linkDeserializer des0 (
		.top_in_clk  (top_in_clk),
		.arstN       (arstN),
		.topIn       (topIn),
		.topValidIn  (topValidIn),
		.fifoFull    (rxFull),
		.topReadyOut (topReadyOut),
		.wordPush    (rxPush),
		.wordData    (rxData)
	);

	// inbound queue, link to host
	wordFifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) rxFifo0 (
		.top_in_clk (top_in_clk),
		.arstN      (arstN),
		.push       (rxPush),
		.pushData   (rxData),
		.pop        (pipeOutRead),  // ignored while empty
		.headData   (pipeOutData),
		.empty      (pipeOutEmpty),
		.full       (rxFull)
	);

endmodule

// ==== bench/hostCoreTb.sv ====
`timescale 1ns/1ps

module hostCoreTb;
	import hostCorePkg::*;

	localparam int        FIFO_DEPTH_LOG2 = 3;
	localparam int        TIMEOUT_CYCLES  = 200;       // limit for every wait loop
	localparam hostWord_t NOP_WORD        = 32'h8000_0000; // nop prefix, empty tail
	localparam hostWord_t REF_WORD        = 32'hC0DE_1234; // fixed packet word

	logic      top_in_clk;
	logic      arstN;
	logic      pipeInWrite;
	hostWord_t pipeInData;
	logic      pipeOutRead;
	regId_t    regReadAddr;
	logic      pipeInFull;
	hostWord_t pipeOutData;
	logic      pipeOutEmpty;
	regData_t  regReadData;
	flit_t     topIn;
	logic      topValidIn;
	logic      topReadyOut;
	flit_t     topOut;
	logic      topValidOut;
	logic      topReadyIn;

	integer    seed;
	integer    rnd;
	int        errorCount;
	logic      toggleReady;    // random stalls on the outbound link
	hostWord_t txExpected[$];  // outbound scoreboard, fifo order
	hostWord_t rxExpected[$];  // inbound scoreboard
	regData_t  regModel [32];  // expected register file
	flit_t     outFlits [3];   // flits of the word on topOut
	int        outIdx;
	hostWord_t outWord;
	hostWord_t outExpect;
	flit_t     heldFlits [3];  // inbound word stalled on its last flit

	hostCore #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) dut0 (.*);

	initial begin
		top_in_clk = 1'b0;
		forever #50 top_in_clk = ~top_in_clk; // 100 ns period
	end

	// --------------------------------------------------
	// error reporting
	// --------------------------------------------------

	task automatic reportMismatch(string name, hostWord_t expected, hostWord_t actual);
		errorCount++;
		$display("FAILED %s expected %h actual %h", name, expected, actual);
		$display("test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic reportProblem(string what);
		errorCount++;
		$display("%s", what);
		$display("test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic reportTimeout(string what);
		errorCount++;
		$display("timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
		$display("test failed");
		$fatal(1, "stopping at the first error");
	endtask

	// --------------------------------------------------
	// checkers
	// --------------------------------------------------

	// a stalled flit keeps its value and its valid
	assert property (@(posedge top_in_clk) disable iff (!arstN)
		topValidOut && !topReadyIn |=> topValidOut && $stable(topOut))
	else reportProblem("outbound flit changed while stalled by topReadyIn");

	// outbound monitor, rebuilds words from handshaked flits
	always @(posedge top_in_clk) begin
		if (arstN && topValidOut && topReadyIn) begin
			outFlits[outIdx] = topOut;
			if (outIdx == FLITS_PER_WORD - 1) begin
				outIdx = 0;
				assert (topOut[10] == 1'b0)
				else reportMismatch("lastFlitPad", 32'd0, topOut[10]);
				assert (txExpected.size() != 0)
				else reportProblem("outbound word seen on topOut with nothing queued");
				outWord   = {outFlits[0], outFlits[1], outFlits[2][9:0]};
				outExpect = txExpected.pop_front();
				assert (outWord == outExpect)
				else reportMismatch("outboundWord", outExpect, outWord);
			end else begin
				outIdx++;
			end
		end
	end

	// --------------------------------------------------
	// stimulus tasks
	// --------------------------------------------------

	task automatic stepCycle();
		@(posedge top_in_clk);
		#1; // drive just after the edge
		if (toggleReady) begin
			rnd = $random(seed);
			topReadyIn = rnd[0];
		end
	endtask

	function automatic hostWord_t makePacket(hostWord_t raw);
		// keep clear of the register write and nop patterns
		if (raw[31:30] == 2'b10 && !raw[29]) begin
			raw[29] = 1'b1;
		end
		return raw;
	endfunction

	task automatic writeWord(hostWord_t w);
		pipeInData  = w;
		pipeInWrite = 1'b1; // one-cycle strobe
		stepCycle();
		pipeInWrite = 1'b0;
	endtask

	task automatic writeReg(regId_t id, regData_t data);
		regReadAddr = id;
		writeWord({2'b10, 1'b0, id, 8'h00, data});
		regModel[id] = data;
		assert (regReadData == data) else reportMismatch("regWrite", data, regReadData);
	endtask

	task automatic sendPacket(hostWord_t w);
		int waited;
		waited = 0;
		while (pipeInFull && waited < TIMEOUT_CYCLES) begin
			stepCycle();
			waited++;
		end
		assert (!pipeInFull) else reportTimeout("pipeInFull to clear");
		txExpected.push_back(w);
		writeWord(w);
		stepCycle(); // push lands, so pipeInFull is current again
	endtask

	task automatic offerFlit(flit_t f);
		int waited;
		waited = 0;
		topIn      = f;
		topValidIn = 1'b1;
		while (!topReadyOut && waited < TIMEOUT_CYCLES) begin
			stepCycle();
			waited++;
		end
		assert (topReadyOut) else reportTimeout("topReadyOut to accept a flit");
		stepCycle(); // handshake on this edge
		topValidIn = 1'b0;
	endtask

	task automatic sendInbound();
		for (int i = 0; i < FLITS_PER_WORD; i++) begin
			rnd = $random(seed);
			heldFlits[i] = rnd[10:0]; // bit 10 of the last flit is random too
		end
		for (int i = 0; i < FLITS_PER_WORD; i++) begin
			offerFlit(heldFlits[i]);
		end
		rxExpected.push_back({heldFlits[0], heldFlits[1], heldFlits[2][9:0]});
	endtask

	task automatic readInbound();
		int        waited;
		hostWord_t expWord;
		waited = 0;
		while (pipeOutEmpty && waited < TIMEOUT_CYCLES) begin
			stepCycle();
			waited++;
		end
		assert (!pipeOutEmpty) else reportTimeout("pipeOutEmpty to fall");
		expWord = rxExpected.pop_front();
		assert (pipeOutData == expWord) else reportMismatch("inboundWord", expWord, pipeOutData);
		pipeOutRead = 1'b1;
		stepCycle();
		pipeOutRead = 1'b0;
	endtask

	// send words without reading until the closing flit is refused
	task automatic fillInbound();
		int   words;
		logic stalled;
		words   = 0;
		stalled = 1'b0;
		while (!stalled && words < (4 << FIFO_DEPTH_LOG2)) begin
			for (int i = 0; i < FLITS_PER_WORD; i++) begin
				rnd = $random(seed);
				heldFlits[i] = rnd[10:0];
			end
			offerFlit(heldFlits[0]);
			offerFlit(heldFlits[1]);
			if (topReadyOut) begin
				offerFlit(heldFlits[2]);
				rxExpected.push_back({heldFlits[0], heldFlits[1], heldFlits[2][9:0]});
			end else begin
				stalled = 1'b1;
			end
			words++;
		end
		assert (stalled) else reportProblem("topReadyOut never fell while the inbound FIFO filled");
		assert (rxExpected.size() == (1 << FIFO_DEPTH_LOG2))
		else reportMismatch("rxFillLevel", 1 << FIFO_DEPTH_LOG2, rxExpected.size());
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	initial begin
		int waited;
		seed        = 56;
		errorCount  = 0;
		toggleReady = 1'b0;
		outIdx      = 0;
		arstN       = 1'b0;
		pipeInWrite = 1'b0;
		pipeInData  = '0;
		pipeOutRead = 1'b0;
		regReadAddr = '0;
		topIn       = '0;
		topValidIn  = 1'b0;
		topReadyIn  = 1'b1;
		for (int i = 0; i < 32; i++) begin
			regModel[i] = '0;
		end
		repeat (2) @(posedge top_in_clk); // reset for 2 cycles
		#1;
		arstN = 1'b1;

		// reset state
		assert (!topValidOut) else reportMismatch("resetValidOut", 0, topValidOut);
		assert (topReadyOut) else reportMismatch("resetReadyOut", 1, topReadyOut);
		assert (pipeOutEmpty) else reportMismatch("resetOutEmpty", 1, pipeOutEmpty);
		assert (!pipeInFull) else reportMismatch("resetInFull", 0, pipeInFull);
		assert (regReadData == '0) else reportMismatch("resetCtrlReg", 0, regReadData);

		// packets queue up but the link stays quiet while txEnable is 0
		for (int i = 0; i < 3; i++) begin
			rnd = $random(seed);
			sendPacket(makePacket(rnd));
		end
		repeat (20) begin
			stepCycle();
			assert (!topValidOut) else reportProblem("topValidOut rose while txEnable is 0");
		end

		// random register writes, reg 0 left alone so the link stays off
		for (int i = 0; i < 12; i++) begin
			rnd = $random(seed);
			writeReg(regId_t'(1 + rnd[7:0] % 31), rnd[31:16]);
		end

		// outbound packets with random stalls
		toggleReady = 1'b1;
		writeReg(REG_CTRL, 16'h0001); // txEnable on
		sendPacket(REF_WORD);
		for (int i = 0; i < 12; i++) begin
			rnd = $random(seed);
			sendPacket(makePacket(rnd));
		end
		waited = 0;
		while (txExpected.size() != 0 && waited < TIMEOUT_CYCLES) begin
			stepCycle();
			waited++;
		end
		assert (txExpected.size() == 0) else reportTimeout("the outbound words to drain");
		toggleReady = 1'b0;
		topReadyIn  = 1'b1;

		// nops with the link enabled and idle touch neither registers nor the link
		repeat (3) writeWord(NOP_WORD);
		repeat (5) begin
			stepCycle();
			assert (!topValidOut) else reportProblem("a nop word started the outbound link");
		end
		for (int i = 0; i < 32; i++) begin
			regReadAddr = regId_t'(i);
			#1;
			assert (regReadData == regModel[i])
			else reportMismatch("nopRegister", regModel[i], regReadData);
		end

		// inbound words, one at a time and then two queued
		repeat (6) begin
			sendInbound();
			readInbound();
		end
		sendInbound();
		sendInbound();
		readInbound();
		readInbound();

		// fill until back-pressure, hold the closing flit, then drain
		fillInbound();
		topIn      = heldFlits[2];
		topValidIn = 1'b1;
		repeat (5) begin
			stepCycle();
			assert (!topReadyOut) else reportProblem("topReadyOut rose with the inbound FIFO full");
		end
		readInbound(); // frees one slot
		offerFlit(heldFlits[2]);
		rxExpected.push_back({heldFlits[0], heldFlits[1], heldFlits[2][9:0]});
		while (rxExpected.size() != 0) begin
			readInbound();
		end
		stepCycle();
		assert (pipeOutEmpty) else reportProblem("inbound FIFO holds a word that was never sent");

		if (errorCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== hostCore.f ====
design/hostCorePkg.sv
design/hostWordDecoder.sv
design/wordFifo.sv
design/linkSerializer.sv
design/linkDeserializer.sv
design/hostCore.sv
bench/hostCoreTb.sv
